/* bench/drs_stimulus.txt */
// mask max latency wait_vdd dmode config chn_config stop_cell words completes
// all hex, one readout per line
1FF 009 02 0003 1 05 AA 2A5 5A 1
001 00F 00 0000 0 00 01 3FF 10 1
100 013 05 0010 1 07 55 000 14 1
0A5 00B 3F 0001 1 F8 FF 155 30 1
142 009 01 0020 0 03 80 1C3 1E 1
011 01F 04 0002 1 01 3C 2E0 40 1
0FE 00A 03 0007 1 06 0F 07F 4D 1
080 00C 00 0000 0 00 C3 3A5 0D 1

/* flist.f */
logic/drs_pkg.sv
logic/drs_cycle_timer.sv
logic/drs_serial_loader.sv
logic/drs_channel_walker.sv
logic/drs_sample_capture.sv
logic/drs_sequencer.sv
logic/drs_readout.sv
bench/drs_readout_tb.sv

/* Makefile */
TOP = drs_readout_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/drs_readout_tb.sv */
`timescale 1ns/1ps

module drs_readout_tb;

  localparam int MAX_LINES = 32;
  localparam int FIELDS    = 10;

  logic                           clock;
  logic                           reset;
  drs_pkg::drs_settings_t         settings_i;
  drs_pkg::drs_cmd_t              cmd_i;
  logic                           trigger_i;
  drs_pkg::drs_sample_t           adc_data_i = '0;
  logic                           srout_i = 1'b0;
  drs_pkg::drs_pins_t             pins_o;
  drs_pkg::drs_sample_t           sample_o;
  logic                           sample_valid_o;
  logic [drs_pkg::CELL_WIDTH-1:0] stop_cell_o;
  logic                           readout_complete_o;
  logic                           busy_o;

  // columns per line, see the stimulus file
  logic [31:0] stim [MAX_LINES*FIELDS];
  int          num_lines;
  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 32'h7fff_ffff;

  // settings of the line under test
  logic [8:0]  cur_mask = '0;
  logic [9:0]  cur_max = '0;
  logic [9:0]  cur_cell = '0;
  logic [15:0] cur_wait = '0;

  // running totals, each written by one monitor only
  int          cfg_count = 0;
  int          wsr_count = 0;
  int          word_count = 0;
  int          done_count = 0;
  int          load_count = 0;
  int          stop_cycles = 0;
  int          word_base = 0;
  logic [7:0]  cfg_bits = '0;
  logic [7:0]  wsr_bits = '0;
  drs_pkg::drs_sample_t adc_prev;

  // chip model state
  logic        cell_active = 1'b0;
  int          cell_index = 0;

  drs_readout dut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
    errors++;
  endtask

  function automatic int count_enabled(input logic [8:0] mask);
    int n;
    n = 0;
    for (int i = 0; i < 9; i++) begin
      if (mask[i]) n++;
    end
    return n;
  endfunction

  // channel address of the n-th enabled channel, F when past the end
  function automatic logic [3:0] nth_enabled(input logic [8:0] mask, input int n);
    int         seen;
    logic [3:0] chan;
    seen = 0;
    chan = 4'hF;
    for (int i = 0; i < 9; i++) begin
      if (mask[i]) begin
        if (seen == n) chan = 4'(i);
        seen++;
      end
    end
    return chan;
  endfunction

  // ------------------------------
  // stimulus and chip model
  // ------------------------------
  always @(posedge clock) begin
    adc_prev   <= adc_data_i;
    adc_data_i <= drs_pkg::drs_sample_t'($urandom);
  end

  // stop cell out msb first, one bit per shift clock after rsrload
  always @(posedge clock) begin
    if (pins_o.rsrload) begin
      cell_active <= 1'b1;
      cell_index  <= 1;
      srout_i     <= cur_cell[drs_pkg::CELL_WIDTH-1];
    end else if (cell_active && pins_o.srclk_en) begin
      if (cell_index < drs_pkg::CELL_WIDTH) begin
        srout_i    <= cur_cell[drs_pkg::CELL_WIDTH-1-cell_index];
        cell_index <= cell_index + 1;
      end else begin
        cell_active <= 1'b0;
        srout_i     <= 1'b0;
      end
    end
  end

  // ------------------------------
  // monitors
  // ------------------------------
  // serial bits seen by the chip under each register address
  always @(posedge clock) begin
    if (pins_o.srclk_en && pins_o.addr == drs_pkg::ADR_CONFIG) begin
      cfg_bits  <= {cfg_bits[6:0], pins_o.srin};
      cfg_count <= cfg_count + 1;
    end
    if (pins_o.srclk_en && pins_o.addr == drs_pkg::ADR_WRITE_SR) begin
      wsr_bits  <= {wsr_bits[6:0], pins_o.srin};
      wsr_count <= wsr_count + 1;
    end
  end

  // rsr load after the stop cycle and the vdd wait, first channel addressed
  always @(posedge clock) begin
    if (pins_o.rsrload) begin
      if (stop_cycles != int'(cur_wait) + 2)
        report_mismatch("pins_o.rsrload delay", stop_cycles, int'(cur_wait) + 2);
      if (pins_o.addr != nth_enabled(cur_mask, 0))
        report_mismatch("pins_o.addr at rsrload", pins_o.addr, nth_enabled(cur_mask, 0));
      if (pins_o.denable !== 1'b1) report_mismatch("pins_o.denable", pins_o.denable, 1);
      load_count <= load_count + 1;
    end
    // wave running with sampling stopped
    if (pins_o.denable && !pins_o.dwrite) begin
      stop_cycles <= stop_cycles + 1;
    end else begin
      stop_cycles <= 0;
    end
  end

  // words in mask order, max+1 per channel
  always @(posedge clock) begin
    if (sample_valid_o) begin
      if (pins_o.addr != nth_enabled(cur_mask, (word_count - word_base) / (int'(cur_max) + 1)))
        report_mismatch("pins_o.addr", pins_o.addr,
                        nth_enabled(cur_mask, (word_count - word_base) / (int'(cur_max) + 1)));
      if (sample_o != adc_prev) report_mismatch("sample_o", sample_o, adc_prev);
      word_count <= word_count + 1;
    end
    if (readout_complete_o) begin
      if (stop_cell_o != cur_cell) report_mismatch("stop_cell_o", stop_cell_o, cur_cell);
      done_count <= done_count + 1;
    end
  end

  // watchdog
  initial begin
    @(posedge clock);
    while (cycles < cycle_limit) begin
      cycles++;
      @(posedge clock);
    end
    $display("timeout: readout did not finish within %0d cycles", cycle_limit);
    $display("words: %0d, errors: %0d", word_count, errors + 1);
    $display("Simulation FAILED");
    $finish;
  end

  // ------------------------------
  // one test line
  // ------------------------------
  task automatic run_line(input int idx);
    drs_pkg::drs_settings_t s;
    int base;
    int cfg_base;
    int wsr_base;
    int done_base;
    int load_base;
    int settle;
    int wait_cycles;
    base                = idx * FIELDS;
    s.readout_mask      = stim[base][8:0];
    s.sample_count_max  = stim[base+1][9:0];
    s.adc_latency       = stim[base+2][5:0];
    s.wait_vdd_clocks   = stim[base+3][15:0];
    s.dmode             = stim[base+4][0];
    s.chip_config       = stim[base+5][7:0];
    s.chn_config        = stim[base+6][7:0];
    // back in IDLE once nreset is released
    @(posedge clock);
    while (!pins_o.nreset) @(posedge clock);
    settings_i <= s;
    cur_mask  = s.readout_mask;
    cur_max   = s.sample_count_max;
    cur_wait  = s.wait_vdd_clocks;
    cur_cell  = stim[base+7][9:0];
    cfg_base  = cfg_count;
    wsr_base  = wsr_count;
    word_base = word_count;
    done_base = done_count;
    load_base = load_count;
    @(posedge clock);
    cmd_i.configure <= 1'b1;
    @(posedge clock);
    cmd_i.configure <= 1'b0;
    while (wsr_count - wsr_base < 8) @(posedge clock);
    // start domino and count the settling cycles
    cmd_i.start <= 1'b1;
    @(posedge clock);
    cmd_i.start <= 1'b0;
    settle = 0;
    @(posedge clock);
    while (busy_o) begin
      settle++;
      @(posedge clock);
    end
    if (settle != drs_pkg::DOMINO_SETTLE_CLOCKS)
      report_mismatch("busy_o high cycles", settle, drs_pkg::DOMINO_SETTLE_CLOCKS);
    if (s.dmode) begin
      wait_cycles = 2 + int'($urandom % 6);
      repeat (wait_cycles) begin
        @(posedge clock);
        if (busy_o) report_mismatch("busy_o", busy_o, 0);
      end
      trigger_i <= 1'b1;
      @(posedge clock);
      trigger_i <= 1'b0;
    end
    while (done_count == done_base) @(posedge clock);
    // leave the domino loop through INIT
    cmd_i.reinit <= 1'b1;
    @(posedge clock);
    cmd_i.reinit <= 1'b0;
    while (pins_o.nreset) @(posedge clock);
    // reserved config bits always go out as ones
    if (cfg_count - cfg_base != 8) report_mismatch("config srclk_en cycles", cfg_count - cfg_base, 8);
    if (cfg_bits != (s.chip_config | 8'hF8))
      report_mismatch("pins_o.srin config", cfg_bits, s.chip_config | 8'hF8);
    if (wsr_count - wsr_base != 8) report_mismatch("wsr srclk_en cycles", wsr_count - wsr_base, 8);
    if (wsr_bits != s.chn_config) report_mismatch("pins_o.srin wsr", wsr_bits, s.chn_config);
    if (load_count - load_base != 1)
      report_mismatch("pins_o.rsrload cycles", load_count - load_base, 1);
    if (word_count - word_base != int'(stim[base+8]))
      report_mismatch("sample_valid_o count", word_count - word_base, stim[base+8]);
    if (done_count - done_base != int'(stim[base+9]))
      report_mismatch("readout_complete_o count", done_count - done_base, stim[base+9]);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    reset      = 1'b1;
    settings_i = '0;
    cmd_i      = '0;
    trigger_i  = 1'b0;
    void'($urandom(36));
    for (int i = 0; i < MAX_LINES * FIELDS; i++) stim[i] = '1;
    $readmemh("bench/drs_stimulus.txt", stim);
    num_lines = 0;
    while (num_lines < MAX_LINES && stim[num_lines*FIELDS] != '1) num_lines++;
    if (num_lines == 0) begin
      $display("no test lines found in bench/drs_stimulus.txt");
      errors++;
    end
    // settle + wait + per channel time + slack, doubled
    cycle_limit = 0;
    for (int i = 0; i < num_lines; i++) begin
      cycle_limit += drs_pkg::DOMINO_SETTLE_CLOCKS + int'(stim[i*FIELDS+3]) + 64 +
                     count_enabled(stim[i*FIELDS][8:0]) *
                     (int'(stim[i*FIELDS+1]) + int'(stim[i*FIELDS+2]) + 8);
    end
    cycle_limit = 2 * cycle_limit;
    repeat (5) @(posedge clock);
    // outputs while still in reset
    if (pins_o.srclk_en !== 1'b0) report_mismatch("pins_o.srclk_en", pins_o.srclk_en, 0);
    if (pins_o.rsrload !== 1'b0) report_mismatch("pins_o.rsrload", pins_o.rsrload, 0);
    if (pins_o.denable !== 1'b0) report_mismatch("pins_o.denable", pins_o.denable, 0);
    if (pins_o.dwrite !== 1'b0) report_mismatch("pins_o.dwrite", pins_o.dwrite, 0);
    if (pins_o.nreset !== 1'b0) report_mismatch("pins_o.nreset", pins_o.nreset, 0);
    if (pins_o.addr !== drs_pkg::ADR_IDLE) report_mismatch("pins_o.addr", pins_o.addr, 4'hB);
    if (sample_valid_o !== 1'b0) report_mismatch("sample_valid_o", sample_valid_o, 0);
    if (readout_complete_o !== 1'b0)
      report_mismatch("readout_complete_o", readout_complete_o, 0);
    if (busy_o !== 1'b1) report_mismatch("busy_o", busy_o, 1);
    reset <= 1'b0;
    for (int i = 0; i < num_lines; i++) run_line(i);
    $display("lines: %0d, words: %0d, errors: %0d", num_lines, word_count, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* logic/drs_readout.sv */
`timescale 1ns/1ps

module drs_readout (
  input  logic                           clock,
  input  logic                           reset,
  input  drs_pkg::drs_settings_t         settings_i,
  input  drs_pkg::drs_cmd_t              cmd_i,
  input  logic                           trigger_i,
  input  drs_pkg::drs_sample_t           adc_data_i,
  input  logic                           srout_i,
  output drs_pkg::drs_pins_t             pins_o,
  output drs_pkg::drs_sample_t           sample_o,
  output logic                           sample_valid_o,
  output logic [drs_pkg::CELL_WIDTH-1:0] stop_cell_o,
  output logic                           readout_complete_o,
  output logic                           busy_o
);

  logic                           timer_start;
  logic [15:0]                    timer_limit;
  logic [15:0]                    timer_count;
  logic                           timer_done;
  logic                           load_config;
  logic                           load_wsr;
  logic                           shift_done;
  logic                           loader_srin;
  logic                           loader_srclk_en;
  logic [drs_pkg::CHAN_WIDTH-1:0] loader_addr;
  logic                           loader_active;
  logic                           walk_start;
  logic                           walk_advance;
  logic [drs_pkg::CHAN_WIDTH-1:0] channel;
  logic                           last_channel;
  logic                           capture_enable;
  logic                           rsr_load;
  logic                           capture_srclk_en;
  logic                           channel_done;
  drs_pkg::drs_domino_t           domino;

  // ------------------------------
  // control
  // ------------------------------
  drs_sequencer u_sequencer (
    .clock, .reset, .settings_i, .cmd_i, .trigger_i,
    .timer_done_i     (timer_done),
    .shift_done_i     (shift_done),
    .channel_done_i   (channel_done),
    .last_channel_i   (last_channel),
    .timer_start_o    (timer_start),
    .timer_limit_o    (timer_limit),
    .load_config_o    (load_config),
    .load_wsr_o       (load_wsr),
    .walk_start_o     (walk_start),
    .walk_advance_o   (walk_advance),
    .capture_enable_o (capture_enable),
    .rsr_load_o       (rsr_load),
    .domino_o         (domino),
    .readout_complete_o, .busy_o
  );

  drs_cycle_timer u_timer (
    .clock, .reset,
    .start_i (timer_start),
    .limit_i (timer_limit),
    .count_o (timer_count),
    .done_o  (timer_done)
  );

  // ------------------------------
  // datapath
  // ------------------------------
  drs_serial_loader u_loader (
    .clock, .reset, .settings_i,
    .load_config_i (load_config),
    .load_wsr_i    (load_wsr),
    .srin_o        (loader_srin),
    .srclk_en_o    (loader_srclk_en),
    .addr_o        (loader_addr),
    .active_o      (loader_active),
    .shift_done_o  (shift_done)
  );

  drs_channel_walker u_walker (
    .clock, .reset,
    .readout_mask_i (settings_i.readout_mask),
    .walk_start_i   (walk_start),
    .walk_advance_i (walk_advance),
    .channel_o      (channel),
    .last_channel_o (last_channel)
  );

  drs_sample_capture u_capture (
    .clock, .reset, .adc_data_i, .srout_i, .settings_i,
    .capture_enable_i (capture_enable),
    .rsr_load_i       (rsr_load),
    .count_i          (timer_count),
    .srclk_en_o       (capture_srclk_en),
    .sample_o, .sample_valid_o, .stop_cell_o,
    .channel_done_o   (channel_done)
  );

  // chip pins, loader owns the address while it shifts
  assign pins_o.addr     = loader_active ? loader_addr : channel;
  assign pins_o.nreset   = domino.nreset;
  assign pins_o.denable  = domino.denable;
  assign pins_o.dwrite   = domino.dwrite;
  assign pins_o.rsrload  = rsr_load;
  assign pins_o.srclk_en = loader_srclk_en | capture_srclk_en;
  assign pins_o.srin     = loader_srin;

endmodule

/* logic/drs_sequencer.sv */
`timescale 1ns/1ps

module drs_sequencer (
  input  logic                   clock,
  input  logic                   reset,
  input  drs_pkg::drs_settings_t settings_i,
  input  drs_pkg::drs_cmd_t      cmd_i,
  input  logic                   trigger_i,
  input  logic                   timer_done_i,
  input  logic                   shift_done_i,
  input  logic                   channel_done_i,
  input  logic                   last_channel_i,
  output logic                   timer_start_o,
  output logic [15:0]            timer_limit_o,
  output logic                   load_config_o,
  output logic                   load_wsr_o,
  output logic                   walk_start_o,
  output logic                   walk_advance_o,
  output logic                   capture_enable_o,
  output logic                   rsr_load_o,
  output drs_pkg::drs_domino_t   domino_o,
  output logic                   readout_complete_o,
  output logic                   busy_o
);

  drs_pkg::seq_state_t state;
  drs_pkg::seq_state_t state_next;

  // ------------------------------
  // next state
  // ------------------------------
  always_comb begin
    state_next = state;
    case (state)
      drs_pkg::INIT: if (timer_done_i) state_next = drs_pkg::IDLE;
      drs_pkg::IDLE: begin
        // configure wins over start
        if (cmd_i.configure) begin
          state_next = drs_pkg::CONF;
        end else if (cmd_i.start) begin
          state_next = drs_pkg::START_RUNNING;
        end
      end
      drs_pkg::CONF: if (shift_done_i) state_next = drs_pkg::WSR;
      drs_pkg::WSR:  if (shift_done_i) state_next = drs_pkg::IDLE;
      drs_pkg::START_RUNNING: if (timer_done_i) state_next = drs_pkg::RUNNING;
      drs_pkg::RUNNING: begin
        // single shot reads at once, otherwise wait for a usable trigger
        if ((trigger_i && |settings_i.readout_mask) || !settings_i.dmode) begin
          state_next = drs_pkg::STOP_DOMINO;
        end
      end
      drs_pkg::STOP_DOMINO: state_next = drs_pkg::WAIT_VDD;
      drs_pkg::WAIT_VDD: if (timer_done_i) state_next = drs_pkg::RSR_LOAD;
      drs_pkg::RSR_LOAD: state_next = drs_pkg::READOUT;
      drs_pkg::READOUT: begin
        if (channel_done_i && last_channel_i) begin
          state_next = drs_pkg::DONE;
        end
      end
      drs_pkg::DONE: state_next = drs_pkg::START_RUNNING;
      default: state_next = drs_pkg::INIT;
    endcase
    // shifts to the chip are never cut short
    if (cmd_i.reinit && state != drs_pkg::CONF && state != drs_pkg::WSR) begin
      state_next = drs_pkg::INIT;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state              <= drs_pkg::INIT;
      readout_complete_o <= 1'b0;
    end else begin
      state              <= state_next;
      // one clock after DONE, stop cell already updated
      readout_complete_o <= (state == drs_pkg::DONE);
    end
  end

  // ------------------------------
  // timer control
  // ------------------------------
  // restart on every state change and on every new channel
  assign timer_start_o = (state_next != state) || walk_advance_o;

  always_comb begin
    case (state)
      drs_pkg::INIT:          timer_limit_o = 16'(drs_pkg::NRESET_CLOCKS - 1);
      drs_pkg::START_RUNNING: timer_limit_o = 16'(drs_pkg::DOMINO_SETTLE_CLOCKS - 1);
      drs_pkg::WAIT_VDD:      timer_limit_o = settings_i.wait_vdd_clocks;
      default:                timer_limit_o = '1;
    endcase
  end

  // strobes to loader, walker and capture
  assign load_config_o    = (state == drs_pkg::IDLE) && (state_next == drs_pkg::CONF);
  assign load_wsr_o       = (state == drs_pkg::CONF) && (state_next == drs_pkg::WSR);
  assign walk_start_o     = (state == drs_pkg::STOP_DOMINO);
  assign walk_advance_o   = (state == drs_pkg::READOUT) && channel_done_i;
  assign capture_enable_o = (state == drs_pkg::READOUT);
  assign rsr_load_o       = (state == drs_pkg::RSR_LOAD);
  // triggers only accepted in RUNNING
  assign busy_o           = (state != drs_pkg::RUNNING);

  // ------------------------------
  // domino lines
  // ------------------------------
  assign domino_o.nreset  = (state != drs_pkg::INIT);
  // wave runs from start until the next init
  assign domino_o.denable = state inside {drs_pkg::START_RUNNING, drs_pkg::RUNNING,
                                          drs_pkg::STOP_DOMINO, drs_pkg::WAIT_VDD,
                                          drs_pkg::RSR_LOAD, drs_pkg::READOUT, drs_pkg::DONE};
  // sampling stops at the trigger, DONE rearms it early
  assign domino_o.dwrite  = state inside {drs_pkg::START_RUNNING, drs_pkg::RUNNING,
                                          drs_pkg::DONE};

  // loader only finishes a byte that this fsm asked for
  shift_in_conf: assert property (@(posedge clock) disable iff (reset)
    shift_done_i |-> state inside {drs_pkg::CONF, drs_pkg::WSR});

endmodule

/* logic/drs_sample_capture.sv */
`timescale 1ns/1ps

module drs_sample_capture (
  input  logic                           clock,
  input  logic                           reset,
  input  drs_pkg::drs_sample_t           adc_data_i,
  input  logic                           srout_i,
  input  logic                           capture_enable_i,
  input  logic                           rsr_load_i,
  input  logic [15:0]                    count_i,
  input  drs_pkg::drs_settings_t         settings_i,
  output logic                           srclk_en_o,
  output drs_pkg::drs_sample_t           sample_o,
  output logic                           sample_valid_o,
  output logic [drs_pkg::CELL_WIDTH-1:0] stop_cell_o,
  output logic                           channel_done_o
);

  drs_pkg::drs_sample_t                        adc_q;
  logic [9:0]                                  sample_cnt;
  logic                                        first_chan;
  logic [$clog2(drs_pkg::CELL_WIDTH+1)-1:0]    stop_bits;
  logic [drs_pkg::CELL_WIDTH-1:0]              stop_shift;
  logic                                        stop_shift_en;

  // adc input flop, same edge as the chip clock
  always_ff @(posedge clock) begin
    adc_q <= adc_data_i;
  end

  // ------------------------------
  // pacing from the cycle count
  // ------------------------------
  // max+1 shift clocks per channel
  assign srclk_en_o     = capture_enable_i && (count_i <= 16'(settings_i.sample_count_max));
  // adc pipeline delay before words are good
  assign sample_valid_o = capture_enable_i && (count_i > 16'(settings_i.adc_latency));
  assign sample_o       = adc_q;
  assign channel_done_o = sample_valid_o && (sample_cnt == settings_i.sample_count_max);

  // stop cell rides on the first ten clocks of the first channel
  assign stop_shift_en  = first_chan && srclk_en_o &&
                          (stop_bits < ($bits(stop_bits))'(drs_pkg::CELL_WIDTH));

  always_ff @(posedge clock) begin
    if (reset || rsr_load_i) begin
      sample_cnt <= '0;
      first_chan <= rsr_load_i;
      stop_bits  <= '0;
    end else begin
      if (channel_done_o) begin
        sample_cnt <= '0;
        first_chan <= 1'b0;
      end else if (sample_valid_o) begin
        sample_cnt <= sample_cnt + 10'd1;
      end
      if (stop_shift_en) begin
        stop_bits <= stop_bits + 1'b1;
      end
    end
  end

  // msb first off the serial line
  always_ff @(posedge clock) begin
    if (stop_shift_en) begin
      stop_shift <= {stop_shift[drs_pkg::CELL_WIDTH-2:0], srout_i};
    end
    if (channel_done_o) begin
      stop_cell_o <= stop_shift;
    end
  end

  // the sequencer restarts the count right after each channel
  channel_gap: assert property (@(posedge clock) disable iff (reset)
    channel_done_o |=> !sample_valid_o);

endmodule

/* logic/drs_channel_walker.sv */
`timescale 1ns/1ps

module drs_channel_walker (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [drs_pkg::NUM_CHANNELS-1:0] readout_mask_i,
  input  logic                             walk_start_i,
  input  logic                             walk_advance_i,
  output logic [drs_pkg::CHAN_WIDTH-1:0]   channel_o,
  output logic                             last_channel_o
);

  logic [drs_pkg::NUM_CHANNELS-1:0] remaining;
  logic [drs_pkg::NUM_CHANNELS-1:0] remaining_next;
  logic [drs_pkg::NUM_CHANNELS-1:0] current_bit;

  // lowest enabled channel of a mask
  function automatic logic [drs_pkg::CHAN_WIDTH-1:0] lowest_set(
    input logic [drs_pkg::NUM_CHANNELS-1:0] bits
  );
    logic [drs_pkg::CHAN_WIDTH-1:0] pos;
    pos = '0;
    for (int i = drs_pkg::NUM_CHANNELS - 1; i >= 0; i--) begin
      if (bits[i]) begin
        pos = i[drs_pkg::CHAN_WIDTH-1:0];
      end
    end
    return pos;
  endfunction

  // ------------------------------
  // mask bookkeeping
  // ------------------------------
  always_comb begin
    current_bit = '0;
    for (int i = 0; i < drs_pkg::NUM_CHANNELS; i++) begin
      current_bit[i] = (channel_o == i[drs_pkg::CHAN_WIDTH-1:0]);
    end
  end

  assign remaining_next = remaining & ~current_bit;
  // nothing above the current channel
  assign last_channel_o = ~|remaining_next;

  always_ff @(posedge clock) begin
    if (reset) begin
      remaining <= '0;
      channel_o <= drs_pkg::ADR_IDLE;
    end else if (walk_start_i) begin
      remaining <= readout_mask_i;
      channel_o <= lowest_set(readout_mask_i);
    end else if (walk_advance_i) begin
      remaining <= remaining_next;
      // back to the idle address once the last channel is read
      channel_o <= last_channel_o ? drs_pkg::ADR_IDLE : lowest_set(remaining_next);
    end
  end

endmodule

/* logic/drs_serial_loader.sv */
`timescale 1ns/1ps

module drs_serial_loader (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           load_config_i,
  input  logic                           load_wsr_i,
  input  drs_pkg::drs_settings_t         settings_i,
  output logic                           srin_o,
  output logic                           srclk_en_o,
  output logic [drs_pkg::CHAN_WIDTH-1:0] addr_o,
  output logic                           active_o,
  output logic                           shift_done_o
);

  logic [drs_pkg::SERIAL_BITS-1:0]         shift_reg;
  logic [$clog2(drs_pkg::SERIAL_BITS)-1:0] bit_cnt;

  // ------------------------------
  // bit count
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      active_o <= 1'b0;
      bit_cnt  <= '0;
    end else if (load_config_i || load_wsr_i) begin
      // a new load may follow the last bit directly
      active_o <= 1'b1;
      bit_cnt  <= '0;
    end else if (shift_done_o) begin
      active_o <= 1'b0;
    end else if (active_o) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // byte and address, msb goes out first
  always_ff @(posedge clock) begin
    if (load_config_i) begin
      shift_reg <= settings_i.chip_config | drs_pkg::CONFIG_FORCED_ONES;
      addr_o    <= drs_pkg::ADR_CONFIG;
    end else if (load_wsr_i) begin
      shift_reg <= settings_i.chn_config;
      addr_o    <= drs_pkg::ADR_WRITE_SR;
    end else if (active_o) begin
      shift_reg <= {shift_reg[drs_pkg::SERIAL_BITS-2:0], 1'b0};
    end
  end

  assign srin_o       = active_o && shift_reg[drs_pkg::SERIAL_BITS-1];
  assign srclk_en_o   = active_o;
  // last bit on the line this cycle
  assign shift_done_o = active_o && (bit_cnt == ($bits(bit_cnt))'(drs_pkg::SERIAL_BITS - 1));

  // every fresh shift gives exactly one byte of clocks
  byte_length: assert property (@(posedge clock) disable iff (reset)
    $rose(active_o) |-> ##(drs_pkg::SERIAL_BITS - 1) shift_done_o);

endmodule

/* logic/drs_cycle_timer.sv */
`timescale 1ns/1ps

module drs_cycle_timer (
  input  logic        clock,
  input  logic        reset,
  input  logic        start_i,
  input  logic [15:0] limit_i,
  output logic [15:0] count_o,
  output logic        done_o
);

  // ------------------------------
  // free running count
  // ------------------------------
  // one counter for settling, vdd wait and readout pacing
  always_ff @(posedge clock) begin
    if (reset) begin
      count_o <= '0;
    end else if (start_i) begin
      // zero on the first cycle of the new interval
      count_o <= '0;
    end else begin
      count_o <= count_o + 16'd1;
    end
  end

  // high for as long as the count sits on the limit
  assign done_o = (count_o == limit_i);

endmodule

/* logic/drs_pkg.sv */
package drs_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int ADC_WIDTH    = 14;
  localparam int NUM_CHANNELS = 9;
  localparam int CHAN_WIDTH   = 4;
  localparam int CELL_WIDTH   = 10;
  localparam int SERIAL_BITS  = 8;

  // reserved config bits 3..7 must always be written as one
  localparam logic [SERIAL_BITS-1:0] CONFIG_FORCED_ONES = 8'hF8;

  // ------------------------------
  // chip addresses
  // ------------------------------
  localparam logic [CHAN_WIDTH-1:0] ADR_READ_SR  = 4'b1011;
  localparam logic [CHAN_WIDTH-1:0] ADR_WRITE_SR = 4'b1101;
  localparam logic [CHAN_WIDTH-1:0] ADR_CONFIG   = 4'b1100;
  localparam logic [CHAN_WIDTH-1:0] ADR_IDLE     = ADR_READ_SR;

  // 105 clocks, about 1.5 domino turns
  localparam int DOMINO_SETTLE_CLOCKS = 105;
  // nreset low time from the datasheet
  localparam int NRESET_CLOCKS        = 2;

  typedef enum logic [4:0] {
    INIT, IDLE, CONF, WSR, START_RUNNING, RUNNING,
    STOP_DOMINO, WAIT_VDD, RSR_LOAD, READOUT, DONE
  } seq_state_t;

  typedef struct packed {
    logic                    dmode;
    logic [5:0]              adc_latency;
    logic [15:0]             wait_vdd_clocks;
    logic [9:0]              sample_count_max;
    logic [SERIAL_BITS-1:0]  chip_config;
    logic [SERIAL_BITS-1:0]  chn_config;
    logic [NUM_CHANNELS-1:0] readout_mask;
  } drs_settings_t;

  typedef struct packed {
    logic start;
    logic reinit;
    logic configure;
  } drs_cmd_t;

  typedef struct packed {
    logic [CHAN_WIDTH-1:0] addr;
    logic                  nreset;
    logic                  denable;
    logic                  dwrite;
    logic                  rsrload;
    logic                  srclk_en;
    logic                  srin;
  } drs_pins_t;

  // domino and chip reset lines from the sequencer
  typedef struct packed {
    logic denable;
    logic dwrite;
    logic nreset;
  } drs_domino_t;

  typedef logic [ADC_WIDTH-1:0] drs_sample_t;

endpackage
